// File: source/mci_lite_pkg.sv
////////////////////////////////////////////////////////////
// Shared types and register map of the management controller
// Modules refer to these by scoped name
////////////////////////////////////////////////////////////

package mci_lite_pkg;

    // Widths that carry a meaning
    typedef logic [3:0]  csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [31:0] err_vec_t;
    typedef logic [31:0] wdt_period_t;

    ////////////////////////////////////////////////////////////
    // Register word addresses
    ////////////////////////////////////////////////////////////
    localparam csr_addr_t ADDR_WDT_EN               = 4'd0;
    localparam csr_addr_t ADDR_WDT_RESTART          = 4'd1;
    localparam csr_addr_t ADDR_WDT_T1_PERIOD        = 4'd2;
    localparam csr_addr_t ADDR_WDT_T2_PERIOD        = 4'd3;
    localparam csr_addr_t ADDR_WDT_STATUS           = 4'd4;
    localparam csr_addr_t ADDR_ERR_FATAL_MASK       = 4'd5;
    localparam csr_addr_t ADDR_ERR_NON_FATAL_MASK   = 4'd6;
    localparam csr_addr_t ADDR_ERR_FATAL_STATUS     = 4'd7;
    localparam csr_addr_t ADDR_ERR_NON_FATAL_STATUS = 4'd8;
    localparam csr_addr_t ADDR_INTR_EN              = 4'd9;
    localparam csr_addr_t ADDR_GENERIC_OUT          = 4'd10;
    localparam csr_addr_t ADDR_GENERIC_IN           = 4'd11;

    // Bit positions in the watchdog status word
    localparam int WDT_T1_BIT = 0;
    localparam int WDT_T2_BIT = 1;

    // Periods out of reset, longest possible
    localparam wdt_period_t RESET_T1_PERIOD = 32'hFFFF_FFFF;
    localparam wdt_period_t RESET_T2_PERIOD = 32'hFFFF_FFFF;

endpackage

// File: source/mci_wdt_if.sv
////////////////////////////////////////////////////////////
// Watchdog control and timeout status between the CSR bank
// and the watchdog counters
////////////////////////////////////////////////////////////

interface mci_wdt_if;

    logic                      wdt_en;
    logic                      t1_restart;
    logic                      t1_serviced;
    mci_lite_pkg::wdt_period_t t1_period;
    mci_lite_pkg::wdt_period_t t2_period;

    // Timeout levels back from the watchdog
    logic                      t1_timeout;
    logic                      t2_timeout;

    modport csr (
        output wdt_en, t1_restart, t1_serviced, t1_period, t2_period,
        input  t1_timeout, t2_timeout
    );

    modport wdt (
        input  wdt_en, t1_restart, t1_serviced, t1_period, t2_period,
        output t1_timeout, t2_timeout
    );

endinterface

// File: source/mci_err_if.sv
////////////////////////////////////////////////////////////
// Error masks, clear pulses and sticky status readback
// between the CSR bank and the interrupt controller
////////////////////////////////////////////////////////////

interface mci_err_if;

    mci_lite_pkg::err_vec_t fatal_mask;
    mci_lite_pkg::err_vec_t non_fatal_mask;
    // One-cycle write-1-to-clear pulses
    mci_lite_pkg::err_vec_t fatal_clr;
    mci_lite_pkg::err_vec_t non_fatal_clr;
    logic                   wdt_intr_en;

    mci_lite_pkg::err_vec_t fatal_status;
    mci_lite_pkg::err_vec_t non_fatal_status;

    modport csr (
        output fatal_mask, non_fatal_mask, fatal_clr, non_fatal_clr, wdt_intr_en,
        input  fatal_status, non_fatal_status
    );

    modport intr (
        input  fatal_mask, non_fatal_mask, fatal_clr, non_fatal_clr, wdt_intr_en,
        output fatal_status, non_fatal_status
    );

endinterface

// File: source/mci_csr_bank.sv
////////////////////////////////////////////////////////////
// Register bank behind the request strobe bus
// Writes land on the request edge, reads return one cycle later
////////////////////////////////////////////////////////////

module mci_csr_bank (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  logic                    write_i,
    input  mci_lite_pkg::csr_addr_t addr_i,
    input  mci_lite_pkg::csr_data_t wdata_i,
    input  mci_lite_pkg::csr_data_t generic_in_i,
    output mci_lite_pkg::csr_data_t rdata_o,
    output logic                    rvalid_o,
    output mci_lite_pkg::csr_data_t generic_out_o,
    mci_wdt_if.csr                  wdt_o,
    mci_err_if.csr                  err_o
);

    logic                      wr_en;
    logic                      rd_en;

    logic                      wdt_en_q;
    mci_lite_pkg::wdt_period_t t1_period_q;
    mci_lite_pkg::wdt_period_t t2_period_q;
    mci_lite_pkg::err_vec_t    fatal_mask_q;
    mci_lite_pkg::err_vec_t    non_fatal_mask_q;
    logic                      intr_en_q;
    mci_lite_pkg::csr_data_t   generic_out_q;

    logic                      t1_restart_q;
    logic                      t1_serviced_q;
    mci_lite_pkg::err_vec_t    fatal_clr_q;
    mci_lite_pkg::err_vec_t    non_fatal_clr_q;

    mci_lite_pkg::csr_data_t   rd_mux;
    mci_lite_pkg::csr_data_t   rdata_q;
    logic                      rvalid_q;

    assign wr_en = req_i & write_i;
    assign rd_en = req_i & ~write_i;

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wdt_en_q         <= 1'b0;
            t1_period_q      <= mci_lite_pkg::RESET_T1_PERIOD;
            t2_period_q      <= mci_lite_pkg::RESET_T2_PERIOD;
            fatal_mask_q     <= '0;
            non_fatal_mask_q <= '0;
            intr_en_q        <= 1'b0;
            generic_out_q    <= '0;
            t1_restart_q     <= 1'b0;
            t1_serviced_q    <= 1'b0;
            fatal_clr_q      <= '0;
            non_fatal_clr_q  <= '0;
        end else begin
            // Pulses last a single cycle unless rewritten
            t1_restart_q    <= 1'b0;
            t1_serviced_q   <= 1'b0;
            fatal_clr_q     <= '0;
            non_fatal_clr_q <= '0;
            if (wr_en) begin
                case (addr_i)
                    mci_lite_pkg::ADDR_WDT_EN:               wdt_en_q <= wdata_i[0];
                    mci_lite_pkg::ADDR_WDT_RESTART:          t1_restart_q <= wdata_i[0];
                    mci_lite_pkg::ADDR_WDT_T1_PERIOD:        t1_period_q <= wdata_i;
                    mci_lite_pkg::ADDR_WDT_T2_PERIOD:        t2_period_q <= wdata_i;
                    mci_lite_pkg::ADDR_WDT_STATUS:
                        t1_serviced_q <= wdata_i[mci_lite_pkg::WDT_T1_BIT];
                    mci_lite_pkg::ADDR_ERR_FATAL_MASK:       fatal_mask_q <= wdata_i;
                    mci_lite_pkg::ADDR_ERR_NON_FATAL_MASK:   non_fatal_mask_q <= wdata_i;
                    mci_lite_pkg::ADDR_ERR_FATAL_STATUS:     fatal_clr_q <= wdata_i;
                    mci_lite_pkg::ADDR_ERR_NON_FATAL_STATUS: non_fatal_clr_q <= wdata_i;
                    mci_lite_pkg::ADDR_INTR_EN:              intr_en_q <= wdata_i[0];
                    mci_lite_pkg::ADDR_GENERIC_OUT:          generic_out_q <= wdata_i;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////
    always_comb begin
        rd_mux = '0;
        case (addr_i)
            mci_lite_pkg::ADDR_WDT_EN:               rd_mux[0] = wdt_en_q;
            mci_lite_pkg::ADDR_WDT_T1_PERIOD:        rd_mux = t1_period_q;
            mci_lite_pkg::ADDR_WDT_T2_PERIOD:        rd_mux = t2_period_q;
            mci_lite_pkg::ADDR_WDT_STATUS: begin
                rd_mux[mci_lite_pkg::WDT_T1_BIT] = wdt_o.t1_timeout;
                rd_mux[mci_lite_pkg::WDT_T2_BIT] = wdt_o.t2_timeout;
            end
            mci_lite_pkg::ADDR_ERR_FATAL_MASK:       rd_mux = fatal_mask_q;
            mci_lite_pkg::ADDR_ERR_NON_FATAL_MASK:   rd_mux = non_fatal_mask_q;
            mci_lite_pkg::ADDR_ERR_FATAL_STATUS:     rd_mux = err_o.fatal_status;
            mci_lite_pkg::ADDR_ERR_NON_FATAL_STATUS: rd_mux = err_o.non_fatal_status;
            mci_lite_pkg::ADDR_INTR_EN:              rd_mux[0] = intr_en_q;
            mci_lite_pkg::ADDR_GENERIC_OUT:          rd_mux = generic_out_q;
            mci_lite_pkg::ADDR_GENERIC_IN:           rd_mux = generic_in_i;
            // Restart and unmapped words read as zero
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

    assign rdata_o       = rdata_q;
    assign rvalid_o      = rvalid_q;
    assign generic_out_o = generic_out_q;

    // Controls toward the watchdog and interrupt controller
    assign wdt_o.wdt_en         = wdt_en_q;
    assign wdt_o.t1_restart     = t1_restart_q;
    assign wdt_o.t1_serviced    = t1_serviced_q;
    assign wdt_o.t1_period      = t1_period_q;
    assign wdt_o.t2_period      = t2_period_q;
    assign err_o.fatal_mask     = fatal_mask_q;
    assign err_o.non_fatal_mask = non_fatal_mask_q;
    assign err_o.fatal_clr      = fatal_clr_q;
    assign err_o.non_fatal_clr  = non_fatal_clr_q;
    assign err_o.wdt_intr_en    = intr_en_q;

endmodule

// File: source/mci_wdt.sv
////////////////////////////////////////////////////////////
// Cascaded two-stage watchdog
// Timer 2 runs only while the timer 1 timeout is unserviced
////////////////////////////////////////////////////////////

module mci_wdt (
    input  logic   clk,
    input  logic   rst_i,
    mci_wdt_if.wdt ctrl_i
);

    mci_lite_pkg::wdt_period_t t1_cnt_q;
    mci_lite_pkg::wdt_period_t t2_cnt_q;
    mci_lite_pkg::wdt_period_t t1_next;
    mci_lite_pkg::wdt_period_t t2_next;
    logic                      t1_timeout_q;
    logic                      t2_timeout_q;

    assign t1_next = t1_cnt_q + 1'b1;
    assign t2_next = t2_cnt_q + 1'b1;

    ////////////////////////////////////////////////////////////
    // Timer 1
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            t1_cnt_q     <= '0;
            t1_timeout_q <= 1'b0;
        end else if (!ctrl_i.wdt_en) begin
            t1_cnt_q     <= '0;
            t1_timeout_q <= 1'b0;
        end else if (ctrl_i.t1_serviced) begin
            t1_cnt_q     <= '0;
            t1_timeout_q <= 1'b0;
        end else if (ctrl_i.t1_restart) begin
            t1_cnt_q <= '0;
        end else if (!t1_timeout_q) begin
            t1_cnt_q <= t1_next;
            // Also catches a period lowered below the running count
            if (t1_next >= ctrl_i.t1_period) begin
                t1_timeout_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Timer 2
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            t2_cnt_q     <= '0;
            t2_timeout_q <= 1'b0;
        end else if (!ctrl_i.wdt_en || !t1_timeout_q || ctrl_i.t1_serviced) begin
            // Timeout level is sticky until reset
            t2_cnt_q <= '0;
        end else if (!t2_timeout_q) begin
            t2_cnt_q <= t2_next;
            if (t2_next >= ctrl_i.t2_period) begin
                t2_timeout_q <= 1'b1;
            end
        end
    end

    assign ctrl_i.t1_timeout = t1_timeout_q;
    assign ctrl_i.t2_timeout = t2_timeout_q;

endmodule

// File: source/mci_intr_ctrl.sv
////////////////////////////////////////////////////////////
// Sticky error capture with masking, and the interrupt
// and NMI outputs driven from the watchdog timeouts
////////////////////////////////////////////////////////////

module mci_intr_ctrl (
    input  logic                   clk,
    input  logic                   rst_i,
    input  mci_lite_pkg::err_vec_t agg_error_fatal_i,
    input  mci_lite_pkg::err_vec_t agg_error_non_fatal_i,
    input  logic                   t1_timeout_i,
    input  logic                   t2_timeout_i,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o,
    output logic                   mci_intr_o,
    output logic                   nmi_o,
    mci_err_if.intr                err_i
);

    mci_lite_pkg::err_vec_t fatal_status_q;
    mci_lite_pkg::err_vec_t non_fatal_status_q;
    logic                   all_fatal_q;
    logic                   all_non_fatal_q;
    logic                   mci_intr_q;
    logic                   nmi_q;

    ////////////////////////////////////////////////////////////
    // Sticky status, write 1 to clear
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            fatal_status_q     <= '0;
            non_fatal_status_q <= '0;
        end else begin
            // An input still high wins over its clear
            fatal_status_q     <= (fatal_status_q & ~err_i.fatal_clr) | agg_error_fatal_i;
            non_fatal_status_q <= (non_fatal_status_q & ~err_i.non_fatal_clr)
                                  | agg_error_non_fatal_i;
        end
    end

    // Registered SoC outputs
    always_ff @(posedge clk) begin
        if (rst_i) begin
            all_fatal_q     <= 1'b0;
            all_non_fatal_q <= 1'b0;
            mci_intr_q      <= 1'b0;
            nmi_q           <= 1'b0;
        end else begin
            all_fatal_q     <= |(fatal_status_q & ~err_i.fatal_mask);
            all_non_fatal_q <= |(non_fatal_status_q & ~err_i.non_fatal_mask);
            mci_intr_q      <= t1_timeout_i & err_i.wdt_intr_en;
            nmi_q           <= t2_timeout_i;
        end
    end

    assign err_i.fatal_status     = fatal_status_q;
    assign err_i.non_fatal_status = non_fatal_status_q;

    assign all_error_fatal_o     = all_fatal_q;
    assign all_error_non_fatal_o = all_non_fatal_q;
    assign mci_intr_o            = mci_intr_q;
    assign nmi_o                 = nmi_q;

endmodule

// File: source/mci_lite_top.sv
////////////////////////////////////////////////////////////
// Top level of the management controller
// Bus, error inputs and interrupt outputs as plain ports
////////////////////////////////////////////////////////////

module mci_lite_top (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  logic                    write_i,
    input  mci_lite_pkg::csr_addr_t addr_i,
    input  mci_lite_pkg::csr_data_t wdata_i,
    input  mci_lite_pkg::csr_data_t generic_in_i,
    input  mci_lite_pkg::err_vec_t  agg_error_fatal_i,
    input  mci_lite_pkg::err_vec_t  agg_error_non_fatal_i,
    output mci_lite_pkg::csr_data_t rdata_o,
    output logic                    rvalid_o,
    output mci_lite_pkg::csr_data_t generic_out_o,
    output logic                    all_error_fatal_o,
    output logic                    all_error_non_fatal_o,
    output logic                    mci_intr_o,
    output logic                    nmi_o
);

    mci_wdt_if u_wdt_if ();
    mci_err_if u_err_if ();

    // Input side
    mci_csr_bank u_csr_bank (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .write_i       (write_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .generic_in_i  (generic_in_i),
        .rdata_o       (rdata_o),
        .rvalid_o      (rvalid_o),
        .generic_out_o (generic_out_o),
        .wdt_o         (u_wdt_if.csr),
        .err_o         (u_err_if.csr)
    );

    mci_wdt u_wdt (
        .clk    (clk),
        .rst_i  (rst_i),
        .ctrl_i (u_wdt_if.wdt)
    );

    // Output side
    mci_intr_ctrl u_intr_ctrl (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .t1_timeout_i          (u_wdt_if.t1_timeout),
        .t2_timeout_i          (u_wdt_if.t2_timeout),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o),
        .mci_intr_o            (mci_intr_o),
        .nmi_o                 (nmi_o),
        .err_i                 (u_err_if.intr)
    );

endmodule

// File: verif/mci_lite_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the management controller top level
// Register, error and watchdog tests with a closing report
////////////////////////////////////////////////////////////

module mci_lite_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int T1_TICKS      = 20;
    localparam int T2_TICKS      = 30;
    localparam int SEL_INTR      = 0;
    localparam int SEL_NMI       = 1;
    localparam int SEL_FATAL     = 2;
    localparam int SEL_NON_FATAL = 3;

    logic                    clk = 1'b0;
    logic                    rst_i;
    logic                    req_i;
    logic                    write_i;
    mci_lite_pkg::csr_addr_t addr_i;
    mci_lite_pkg::csr_data_t wdata_i;
    mci_lite_pkg::csr_data_t generic_in_i;
    mci_lite_pkg::err_vec_t  agg_error_fatal_i;
    mci_lite_pkg::err_vec_t  agg_error_non_fatal_i;
    mci_lite_pkg::csr_data_t rdata_o;
    logic                    rvalid_o;
    mci_lite_pkg::csr_data_t generic_out_o;
    logic                    all_error_fatal_o;
    logic                    all_error_non_fatal_o;
    logic                    mci_intr_o;
    logic                    nmi_o;

    logic [31:0] rand_state      = 32'heebb;
    int          error_count     = 0;
    int          errors_at_start = 0;
    int          test_count      = 0;
    string       test_name       = "reset";

    // Plain read/write registers, generic output last
    mci_lite_pkg::csr_addr_t rw_addrs [6] = '{
        mci_lite_pkg::ADDR_ERR_FATAL_MASK, mci_lite_pkg::ADDR_ERR_NON_FATAL_MASK,
        mci_lite_pkg::ADDR_WDT_T1_PERIOD,  mci_lite_pkg::ADDR_WDT_T2_PERIOD,
        mci_lite_pkg::ADDR_INTR_EN,        mci_lite_pkg::ADDR_GENERIC_OUT
    };

    mci_lite_top u_mci_lite_top (.*);

    always #10 clk = ~clk;

    // Read data valid exactly one cycle after each read request
    assert property (@(posedge clk) disable iff (rst_i)
        rvalid_o == $past(req_i && !write_i))
    else begin
        error_count++;
        $display("rvalid_o did not follow a read request by one cycle in %s", test_name);
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic watched_level(input int sel);
        case (sel)
            SEL_INTR:  return mci_intr_o;
            SEL_NMI:   return nmi_o;
            SEL_FATAL: return all_error_fatal_o;
            default:   return all_error_non_fatal_o;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            error_count++;
            $display("[ERROR] %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_window(input string what, input int lo, input int hi,
                                input int actual);
        assert (actual >= lo && actual <= hi)
        else begin
            error_count++;
            $display("[ERROR] %s %s expected %0d..%0d actual %0d",
                     test_name, what, lo, hi, actual);
        end
    endtask

    task automatic finish_test();
        test_count++;
        $display("Test %-12s done, %0d errors", test_name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic bus_write(input mci_lite_pkg::csr_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        req_i   <= 1'b1;
        write_i <= 1'b1;
        addr_i  <= addr;
        wdata_i <= data;
        @(posedge clk);
        req_i   <= 1'b0;
        write_i <= 1'b0;
    endtask

    task automatic bus_read(input mci_lite_pkg::csr_addr_t addr, output logic [31:0] data);
        int waited;
        @(posedge clk);
        req_i   <= 1'b1;
        write_i <= 1'b0;
        addr_i  <= addr;
        @(posedge clk);
        req_i <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rvalid_o && waited < 8);
        if (!rvalid_o) begin
            stop_on_timeout("read data valid");
        end
        data = rdata_o;
    endtask

    // Counts falling edges until the selected output reaches the level
    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (watched_level(sel) !== level && cycles < limit);
        if (watched_level(sel) !== level) begin
            stop_on_timeout(what);
        end
    endtask

    task automatic pulse_error(input bit fatal, input logic [31:0] vec);
        @(posedge clk);
        if (fatal) begin
            agg_error_fatal_i <= vec;
        end else begin
            agg_error_non_fatal_i <= vec;
        end
        @(posedge clk);
        agg_error_fatal_i     <= '0;
        agg_error_non_fatal_i <= '0;
    endtask

    task automatic error_path(input bit fatal);
        mci_lite_pkg::csr_addr_t mask_addr;
        mci_lite_pkg::csr_addr_t status_addr;
        logic [31:0]             vec;
        logic [31:0]             rd;
        int                      sel;
        int                      cycles;
        mask_addr   = fatal ? mci_lite_pkg::ADDR_ERR_FATAL_MASK
                            : mci_lite_pkg::ADDR_ERR_NON_FATAL_MASK;
        status_addr = fatal ? mci_lite_pkg::ADDR_ERR_FATAL_STATUS
                            : mci_lite_pkg::ADDR_ERR_NON_FATAL_STATUS;
        sel = fatal ? SEL_FATAL : SEL_NON_FATAL;
        vec = next_random();
        vec = 32'h1 << vec[4:0];
        // Unmasked source
        bus_write(mask_addr, '0);
        pulse_error(fatal, vec);
        wait_level(sel, 1'b1, 10, "error output to rise", cycles);
        bus_read(status_addr, rd);
        check_value("sticky status", vec, rd);
        bus_read(status_addr, rd);
        check_value("status held", vec, rd);
        bus_write(status_addr, vec);
        wait_level(sel, 1'b0, 10, "error output to drop", cycles);
        bus_read(status_addr, rd);
        check_value("status cleared", '0, rd);
        // Same source masked
        bus_write(mask_addr, vec);
        pulse_error(fatal, vec);
        bus_read(status_addr, rd);
        check_value("masked status", vec, rd);
        check_value("masked output", '0, watched_level(sel));
        bus_write(status_addr, vec);
        bus_write(mask_addr, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] val;
        logic [31:0] exp_val;
        int          cycles;
        rst_i                 <= 1'b1;
        req_i                 <= 1'b0;
        write_i               <= 1'b0;
        addr_i                <= '0;
        wdata_i               <= '0;
        generic_in_i          <= '0;
        agg_error_fatal_i     <= '0;
        agg_error_non_fatal_i <= '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);

        check_value("rvalid_o", '0, rvalid_o);
        check_value("mci_intr_o", '0, mci_intr_o);
        check_value("nmi_o", '0, nmi_o);
        check_value("all_error_fatal_o", '0, all_error_fatal_o);
        check_value("all_error_non_fatal_o", '0, all_error_non_fatal_o);
        check_value("generic_out_o", '0, generic_out_o);
        finish_test();

        test_name = "readback";
        foreach (rw_addrs[i]) begin
            val = next_random();
            bus_write(rw_addrs[i], val);
            bus_read(rw_addrs[i], rd);
            // Interrupt enable holds a single bit
            exp_val = (rw_addrs[i] == mci_lite_pkg::ADDR_INTR_EN) ? {31'b0, val[0]} : val;
            check_value($sformatf("address %0d", rw_addrs[i]), exp_val, rd);
        end
        check_value("generic_out_o", val, generic_out_o);
        val = next_random();
        @(posedge clk);
        generic_in_i <= val;
        bus_read(mci_lite_pkg::ADDR_GENERIC_IN, rd);
        check_value("generic input", val, rd);
        bus_read(4'd15, rd);
        check_value("unmapped address", '0, rd);
        finish_test();

        test_name = "err_fatal";
        error_path(1'b1);
        finish_test();
        test_name = "err_nonfatal";
        error_path(1'b0);
        finish_test();

        test_name = "wdt_stage1";
        bus_write(mci_lite_pkg::ADDR_WDT_T1_PERIOD, T1_TICKS);
        bus_write(mci_lite_pkg::ADDR_WDT_T2_PERIOD, T2_TICKS);
        bus_write(mci_lite_pkg::ADDR_INTR_EN, 32'h1);
        bus_write(mci_lite_pkg::ADDR_WDT_EN, 32'h1);
        wait_level(SEL_INTR, 1'b1, T1_TICKS + 20, "watchdog interrupt", cycles);
        check_window("interrupt latency", T1_TICKS, T1_TICKS + 4, cycles);
        bus_read(mci_lite_pkg::ADDR_WDT_STATUS, rd);
        check_value("status after timeout", 32'h1, rd);
        bus_write(mci_lite_pkg::ADDR_WDT_STATUS, 32'h1);
        wait_level(SEL_INTR, 1'b0, 10, "interrupt to clear", cycles);
        bus_read(mci_lite_pkg::ADDR_WDT_STATUS, rd);
        check_value("status after service", '0, rd);
        finish_test();

        test_name = "wdt_restart";
        repeat (6) begin
            bus_write(mci_lite_pkg::ADDR_WDT_RESTART, 32'h1);
            repeat (T1_TICKS / 2) begin
                @(negedge clk);
                check_value("interrupt while restarted", '0, mci_intr_o);
            end
        end
        finish_test();

        test_name = "wdt_cascade";
        wait_level(SEL_INTR, 1'b1, T1_TICKS + 20, "watchdog interrupt", cycles);
        wait_level(SEL_NMI, 1'b1, T2_TICKS + 20, "NMI", cycles);
        check_window("NMI after interrupt", T2_TICKS, T2_TICKS + 4, cycles);
        repeat (5) @(negedge clk);
        check_value("NMI held", 32'h1, nmi_o);
        bus_read(mci_lite_pkg::ADDR_WDT_STATUS, rd);
        check_value("status both stages", 32'h3, rd);
        // First stage again with the interrupt disabled
        bus_write(mci_lite_pkg::ADDR_WDT_EN, '0);
        bus_write(mci_lite_pkg::ADDR_INTR_EN, '0);
        bus_write(mci_lite_pkg::ADDR_WDT_EN, 32'h1);
        repeat (T1_TICKS + 8) begin
            @(negedge clk);
            check_value("interrupt disabled", '0, mci_intr_o);
        end
        bus_read(mci_lite_pkg::ADDR_WDT_STATUS, rd);
        check_value("status with interrupt off", 32'h3, rd);
        check_value("NMI still held", 32'h1, nmi_o);
        finish_test();

        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
source/mci_lite_pkg.sv
source/mci_wdt_if.sv
source/mci_err_if.sv
source/mci_csr_bank.sv
source/mci_wdt.sv
source/mci_intr_ctrl.sv
source/mci_lite_top.sv
verif/mci_lite_tb.sv
